// ==== all.f ====
hw/tx_pma_pkg.sv
hw/tx_word_fifo.sv
hw/tx_clk_gen.sv
hw/tx_serializer.sv
hw/tx_driver.sv
hw/tx_pma_ch.sv
verif/tb_clk_rst.sv
verif/tb_tx_pma_ch.sv

// ==== Makefile ====
TOP = tb_tx_pma_ch

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_tx_pma_ch.sv ====
// testbench for the transmit lane with a credit-driven sender, a lane model and checking assertions
`timescale 1ns/1ns

module tb_tx_pma_ch import tx_pma_pkg::*;;

  localparam int fifo_depth = 4;
  localparam int det_cycles = 16;
  localparam int n_words    = 24;
  localparam int step_limit = 400;
  localparam int det_limit  = 60;

  logic clk, rst_n;
  tx_word_t word_in;
  logic txelecidl, txdetrx, rx_present, seriallpbken;
  logic credit_return, clkdivtx, dataout, seriallpbkout, rxdetectvalid, rxfound;

  int seed = 32'hcf4a;
  int errors = 0;
  int tests = 0;
  int credits = fifo_depth;
  int consumed = 0;
  int cyc, k, det_left;
  logic send_en = 1'b0;
  logic [9:0] q[$];
  logic [9:0] cur_w, prev_w, tmp_w;
  logic exp_load, exp_dataout, exp_ser, exp_credit, credit_pend;
  logic det_busy, exp_rxvalid, exp_found;

  tb_clk_rst i_tb_clk_rst (.clk(clk), .rst_n(rst_n));

  tx_pma_ch #(
    .fifo_depth (fifo_depth),
    .tx_clk_div (div1),
    .det_cycles (det_cycles)
  ) i_tx_pma_ch (
    .clk(clk), .rst_n(rst_n), .word_in(word_in), .txelecidl(txelecidl),
    .txdetrx(txdetrx), .rx_present(rx_present), .seriallpbken(seriallpbken),
    .credit_return(credit_return), .clkdivtx(clkdivtx), .dataout(dataout),
    .seriallpbkout(seriallpbkout), .rxdetectvalid(rxdetectvalid), .rxfound(rxfound)
  );

  // lane model called once per falling edge before new inputs go out
  task automatic update_model();
    if (!rst_n) begin
      cyc = 0;
      k = 0;
      det_left = 0;
      q.delete();
      cur_w = '0;
      prev_w = '0;
      credit_pend = 1'b0;
      exp_credit = 1'b0;
      exp_load = 1'b0;
      exp_dataout = 1'b0;
      exp_ser = 1'b0;
      det_busy = 1'b0;
      exp_rxvalid = 1'b0;
      exp_found = 1'b0;
      return;
    end
    cyc++;
    // a word pushed at the last rising edge is visible to the next load
    if (word_in.valid) q.push_back(word_in.data);
    exp_credit = credit_pend;
    credit_pend = 1'b0;
    // word-load slot every 10 bits with the first one 10 cycles after release
    exp_load = (cyc % 10 == 0);
    if (exp_load) begin
      prev_w = cur_w;
      k = 0;
      if (q.size() > 0) begin
        cur_w = q.pop_front();
        credit_pend = 1'b1;
        consumed++;
      end else begin
        // underrun slot goes out as zeros
        cur_w = '0;
      end
    end else begin
      k++;
    end
    // serial bit i sits at load+1+i and line bit i at load+2+i
    tmp_w = (k >= 1) ? (cur_w >> (k - 1)) : (prev_w >> 9);
    exp_ser = tmp_w[0];
    tmp_w = (k >= 2) ? (cur_w >> (k - 2)) : (prev_w >> (8 + k));
    exp_dataout = txelecidl ? 1'b0 : tmp_w[0];
    // detect report lands det_cycles+2 cycles after the request cycle
    exp_rxvalid = 1'b0;
    if (det_busy) begin
      det_left--;
      if (det_left == 1) begin
        exp_rxvalid = 1'b1;
        exp_found = rx_present;
      end else if (det_left == 0) begin
        // a request made during the report cycle is still dropped
        det_busy = 1'b0;
      end
    end else if (txdetrx) begin
      det_busy = 1'b1;
      det_left = det_cycles + 2;
    end
  endtask

  // one clock step with inputs changing only on the falling edge
  task automatic step();
    @(negedge clk);
    update_model();
    if (rst_n && credit_return) credits++;
    if (send_en && credits > 0) begin
      word_in = '{data: 10'($random(seed)), valid: 1'b1};
      credits--;
    end else begin
      word_in = '0;
    end
  endtask

  task automatic run_cycles(input int n);
    repeat (n) step();
  endtask

  task automatic wait_consumed(input int target);
    int t;
    for (t = 0; t < step_limit && consumed < target; t++) step();
    if (consumed < target) begin
      $display("timeout waiting for %0d words to be consumed", target);
      errors++;
    end
  endtask

  task automatic wait_report();
    int t;
    for (t = 0; t < det_limit && !rxdetectvalid; t++) step();
    if (!rxdetectvalid) begin
      $display("timeout waiting for rxdetectvalid");
      errors++;
    end
    step();
  endtask

  task automatic pulse_detect();
    txdetrx = 1'b1;
    step();
    txdetrx = 1'b0;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s finished, errors so far %0d", name, errors);
  endtask

  a_clkdivtx: assert property (@(posedge clk) disable iff (!rst_n)
    clkdivtx == exp_load)
    else begin
      errors++;
      $display("** Error clkdivtx got %h expected %h",
        $sampled(clkdivtx), $sampled(exp_load));
    end
  a_dataout: assert property (@(posedge clk) disable iff (!rst_n)
    dataout == exp_dataout)
    else begin
      errors++;
      $display("** Error dataout got %h expected %h",
        $sampled(dataout), $sampled(exp_dataout));
    end
  a_credit: assert property (@(posedge clk) disable iff (!rst_n)
    credit_return == exp_credit)
    else begin
      errors++;
      $display("** Error credit_return got %h expected %h",
        $sampled(credit_return), $sampled(exp_credit));
    end
  a_lpbk: assert property (@(posedge clk) disable iff (!rst_n)
    seriallpbkout == (seriallpbken & exp_ser))
    else begin
      errors++;
      $display("** Error seriallpbkout got %h expected %h",
        $sampled(seriallpbkout), $sampled(seriallpbken & exp_ser));
    end
  a_rxvalid: assert property (@(posedge clk) disable iff (!rst_n)
    rxdetectvalid == exp_rxvalid)
    else begin
      errors++;
      $display("** Error rxdetectvalid got %h expected %h",
        $sampled(rxdetectvalid), $sampled(exp_rxvalid));
    end
  a_rxfound: assert property (@(posedge clk) disable iff (!rst_n)
    rxfound == exp_found)
    else begin
      errors++;
      $display("** Error rxfound got %h expected %h",
        $sampled(rxfound), $sampled(exp_found));
    end
  // outstanding words stay within the buffer depth
  a_credits: assert property (@(posedge clk) credits >= 0 && credits <= fifo_depth)
    else begin
      errors++;
      $display("credit count left its legal range");
    end

  initial begin
    int t;
    word_in = '0;
    txelecidl = 1'b0;
    txdetrx = 1'b0;
    rx_present = 1'b0;
    seriallpbken = 1'b0;
    for (t = 0; t < 20 && !rst_n; t++) step();
    if (!rst_n) begin
      $display("reset never released");
      errors++;
    end
    run_cycles(25);
    end_test("reset_state");
    send_en = 1'b1;
    wait_consumed(n_words);
    end_test("serialization");
    // stall long enough for underrun slots
    send_en = 1'b0;
    run_cycles(40);
    send_en = 1'b1;
    wait_consumed(consumed + 6);
    end_test("credit_flow");
    txelecidl = 1'b1;
    wait_consumed(consumed + 4);
    txelecidl = 1'b0;
    run_cycles(12);
    end_test("elec_idle");
    seriallpbken = 1'b1;
    run_cycles(40);
    seriallpbken = 1'b0;
    run_cycles(20);
    end_test("loopback");
    send_en = 1'b0;
    // found first so the absent run has to clear rxfound
    rx_present = 1'b1;
    pulse_detect();
    wait_report();
    rx_present = 1'b0;
    pulse_detect();
    wait_report();
    // second request while busy must be dropped
    rx_present = 1'b1;
    pulse_detect();
    run_cycles(5);
    pulse_detect();
    wait_report();
    run_cycles(det_cycles + 6);
    end_test("rx_detect");
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verif/tb_clk_rst.sv ====
// testbench clock and reset source, 10 ns period, reset held for 3 cycles
`timescale 1ns/1ns

module tb_clk_rst (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release on a falling edge, away from the flops
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== hw/tx_pma_ch.sv ====
// transmit lane top level, word buffer, clock generation, serializer and output driver
`timescale 1ns/1ns

module tx_pma_ch import tx_pma_pkg::*; #(
  parameter int       fifo_depth = 4,
  parameter clk_div_e tx_clk_div = div1,
  parameter int       det_cycles = 16
) (
  input  logic     clk,
  input  logic     rst_n,
  input  tx_word_t word_in,
  input  logic     txelecidl,
  input  logic     txdetrx,
  input  logic     rx_present,
  input  logic     seriallpbken,
  output logic     credit_return,
  output logic     clkdivtx,
  output logic     dataout,
  output logic     seriallpbkout,
  output logic     rxdetectvalid,
  output logic     rxfound
);

  logic     bit_en;
  logic     ser_bit;
  tx_word_t head;

  // word-load pulse doubles as the parallel clock output clkdivtx
  tx_clk_gen #(
    .tx_clk_div (tx_clk_div)
  ) i_tx_clk_gen (
    .clk    (clk),
    .rst_n  (rst_n),
    .bit_en (bit_en),
    .load   (clkdivtx)
  );

  tx_word_fifo #(
    .fifo_depth (fifo_depth)
  ) i_tx_word_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .word_in       (word_in),
    .load          (clkdivtx),
    .head          (head),
    .credit_return (credit_return)
  );

  tx_serializer i_tx_serializer (
    .clk           (clk),
    .rst_n         (rst_n),
    .bit_en        (bit_en),
    .load          (clkdivtx),
    .head          (head),
    .seriallpbken  (seriallpbken),
    .ser_bit       (ser_bit),
    .seriallpbkout (seriallpbkout)
  );

  tx_driver #(
    .det_cycles (det_cycles)
  ) i_tx_driver (
    .clk           (clk),
    .rst_n         (rst_n),
    .ser_bit       (ser_bit),
    .txelecidl     (txelecidl),
    .txdetrx       (txdetrx),
    .rx_present    (rx_present),
    .dataout       (dataout),
    .rxdetectvalid (rxdetectvalid),
    .rxfound       (rxfound)
  );

endmodule

// ==== hw/tx_driver.sv ====
// transmit output driver with electrical idle forcing and receiver detect sequencer
`timescale 1ns/1ns

module tx_driver import tx_pma_pkg::*; #(
  parameter int det_cycles = 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic ser_bit,
  input  logic txelecidl,
  input  logic txdetrx,
  input  logic rx_present,
  output logic dataout,
  output logic rxdetectvalid,
  output logic rxfound
);

  localparam int cnt_w = (det_cycles > 1) ? $clog2(det_cycles) : 1;

  det_state_e       det_state;
  logic [cnt_w-1:0] charge_cnt;
  logic             charge_done;

  // last cycle of the charge phase
  assign charge_done = (charge_cnt == cnt_w'(det_cycles - 1));

  // output stage, one register after the serializer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dataout <= 1'b0;
    end else begin
      // electrical idle holds the line low while serial data keeps running behind it
      dataout <= txelecidl ? 1'b0 : ser_bit;
    end
  end

  // receiver detect sequencer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      det_state  <= det_idle;
      charge_cnt <= '0;
      rxfound    <= 1'b0;
    end else begin
      case (det_state)
        det_idle: begin
          // requests only count here so busy ones are dropped
          if (txdetrx) begin
            det_state  <= det_charge;
            charge_cnt <= '0;
          end
        end
        det_charge: begin
          if (charge_done) begin
            det_state <= det_sense;
          end else begin
            charge_cnt <= charge_cnt + 1'b1;
          end
        end
        det_sense: begin
          // result is held until the next sense
          rxfound   <= rx_present;
          det_state <= det_report;
        end
        default: begin
          // det_report lasts one cycle
          det_state <= det_idle;
        end
      endcase
    end
  end

  // report pulse det_cycles + 2 cycles after the request
  assign rxdetectvalid = (det_state == det_report);

  // an accepted request always ends in a report after the full charge and sense phases
  a_detect_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (txdetrx && det_state == det_idle) |-> ##(det_cycles + 2) rxdetectvalid);

endmodule

// ==== hw/tx_serializer.sv ====
// parallel-to-serial shifter for the transmit lane that sends LSB first and has a loopback tap
`timescale 1ns/1ns

module tx_serializer import tx_pma_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     bit_en,
  input  logic     load,
  input  tx_word_t head,
  input  logic     seriallpbken,
  output logic     ser_bit,
  output logic     seriallpbkout
);

  logic [word_w-1:0] shift_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // cleared so the line starts at 0
      shift_q <= '0;
    end else if (load) begin
      // empty buffer at a load slot sends an all-zero word
      shift_q <= head.valid ? head.data : '0;
    end else if (bit_en) begin
      // next bit toward the LSB with zeros filling from the top
      shift_q <= {1'b0, shift_q[word_w-1:1]};
    end
  end

  // bit 0 of the loaded word is on the line the cycle after load
  assign ser_bit = shift_q[0];

  // loopback tap without an extra register
  assign seriallpbkout = seriallpbken & ser_bit;

  // the shifter expects a word load only on a bit boundary
  a_load_on_bit: assert property (@(posedge clk) disable iff (!rst_n)
    load |-> bit_en);

endmodule

// ==== hw/tx_clk_gen.sv ====
// clock generation for the transmit lane making the bit strobe and word-load pulse from clk
`timescale 1ns/1ns

module tx_clk_gen import tx_pma_pkg::*; #(
  parameter clk_div_e tx_clk_div = div1
) (
  input  logic clk,
  input  logic rst_n,
  output logic bit_en,
  output logic load
);

  // divisor 1, 2, 4 or 8
  localparam int div_n     = 1 << int'(tx_clk_div);
  localparam int bit_cnt_w = $clog2(word_w);

  logic [2:0]           div_cnt;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic                 div_wrap;
  logic                 bit_wrap;

  // last clk of a bit period
  assign div_wrap = (div_cnt == 3'(div_n - 1));
  // last bit of a word
  assign bit_wrap = (bit_cnt == bit_cnt_w'(word_w - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      bit_cnt <= '0;
      bit_en  <= 1'b0;
      load    <= 1'b0;
    end else begin
      // both strobes registered so the first bit_en comes div_n cycles after reset
      bit_en <= div_wrap;
      // load rides on every word_w-th bit strobe
      load   <= div_wrap && bit_wrap;
      if (div_wrap) begin
        div_cnt <= '0;
        bit_cnt <= bit_wrap ? '0 : bit_cnt + 1'b1;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== hw/tx_word_fifo.sv ====
// parallel word buffer for the transmit lane, returns one credit per consumed word
`timescale 1ns/1ns

module tx_word_fifo import tx_pma_pkg::*; #(
  parameter int fifo_depth = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  tx_word_t word_in,
  input  logic     load,
  output tx_word_t head,
  output logic     credit_return
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  // word storage, payload only
  logic [word_w-1:0] mem [fifo_depth];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cnt_w-1:0]  count;
  logic              push;
  logic              pop;

  // sender pushes on every valid cycle, it only does so while holding a credit
  assign push = word_in.valid;
  // pop only on a word-load slot and only if something is queued
  assign pop = load && (count != '0);

  // head of queue goes straight to the serializer
  assign head.data  = mem[rd_ptr];
  assign head.valid = (count != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= word_in.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      // one credit back the cycle after each consumed word
      credit_return <= pop;
      if (push) begin
        // wrap by compare, depth need not be a power of two
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a sender that honours its credits never pushes into a full buffer
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count < cnt_w'(fifo_depth)));

endmodule

// ==== hw/tx_pma_pkg.sv ====
// transmit lane shared types: word width, word struct, clock divide and detect state encodings
package tx_pma_pkg;

  // parallel word width, one serializer load per word
  parameter int word_w = 10;

  // one parallel word on its way into the lane
  // valid marks a push on the input side
  // and a non-empty buffer on the head side
  typedef struct packed {
    logic [word_w-1:0] data;
    logic              valid;
  } tx_word_t;

  // bit period select, divisor is 2**value
  typedef enum logic [1:0] {
    div1 = 2'd0,
    div2 = 2'd1,
    div4 = 2'd2,
    div8 = 2'd3
  } clk_div_e;

  // receiver detect sequencer states
  typedef enum logic [1:0] {
    // waiting for a txdetrx request
    det_idle   = 2'd0,
    // line charge phase, det_cycles long
    det_charge = 2'd1,
    // single cycle where rx_present is sampled
    det_sense  = 2'd2,
    // single cycle report, rxdetectvalid high
    det_report = 2'd3
  } det_state_e;

endpackage
